/* common/matrix_params.svh */
//##########################################################
// matrix geometry and buffer sizes
//##########################################################
`ifndef MATRIX_PARAMS_SVH
`define MATRIX_PARAMS_SVH

// panel address widths
`define MATRIX_ROW_BITS 5
`define MATRIX_COL_BITS 9

// column bytes on the wire, rounded up
`define MATRIX_COL_BYTES ((`MATRIX_COL_BITS + 7) / 8)

`define MATRIX_BYTES_PER_PIXEL 3 // one byte per colour channel

`define MATRIX_RX_DEPTH 4 // also the host's starting credits

`endif

/* common/matrix_pkg.sv */
//##########################################################
// matrix controller types
//##########################################################
package matrix_pkg;

    `include "matrix_params.svh"

    localparam int CHAN_BITS = (`MATRIX_BYTES_PER_PIXEL > 1) ?
        $clog2(`MATRIX_BYTES_PER_PIXEL) : 1;

    typedef logic [`MATRIX_ROW_BITS-1:0] row_t;
    typedef logic [`MATRIX_COL_BITS-1:0] col_t;
    typedef logic [CHAN_BITS-1:0] chan_t;
    typedef logic [7:0] byte_t;
    typedef logic [`MATRIX_BYTES_PER_PIXEL*8-1:0] pixel_t; // channel n in byte n
    typedef logic [7:0] opcode_t;

    localparam opcode_t OPC_WRITE_PIXEL = 8'h01;
    localparam opcode_t OPC_READ_PIXEL  = 8'h02;

    // command dispatcher
    typedef enum logic [1:0] {
        OPCODE,
        WRITE_BUSY,
        READ_BUSY
    } dispatch_state_t;

endpackage

/* hw/cmd_rx_buffer.sv */
//##########################################################
// host byte receive FIFO
//##########################################################
`include "matrix_params.svh"

module cmd_rx_buffer (
    input  logic                clk,
    input  logic                reset,
    input  logic                rx_valid,
    input  matrix_pkg::byte_t   rx_data,
    input  logic                pop,
    output logic                fifo_valid,
    output matrix_pkg::byte_t   fifo_data,
    output logic                credit_return
);
    localparam int DEPTH    = `MATRIX_RX_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    matrix_pkg::byte_t   mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_pop;

    // wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign fifo_valid = (count != '0);
    assign fifo_data  = mem[rd_ptr]; // head entry
    assign do_pop     = pop && fifo_valid;

    // host never sends without a credit, so a write always finds a free slot
    always_ff @(posedge clk) begin
        if (rx_valid)
            mem[wr_ptr] <= rx_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (rx_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({rx_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= do_pop; // one credit per released slot
        end
    end

endmodule

/* control/control_dispatch.sv */
//##########################################################
// command opcode dispatcher
//##########################################################
module control_dispatch (
    input  logic                clk,
    input  logic                reset,
    input  logic                fifo_valid,
    input  matrix_pkg::byte_t   fifo_data,
    output logic                pop,
    output logic                wr_enable,
    output logic                rd_enable,
    output matrix_pkg::byte_t   cmd_data,
    input  logic                wr_done,
    input  logic                rd_done,
    input  logic                rd_busy
);
    matrix_pkg::dispatch_state_t state;
    logic                        take; // head byte accepted this cycle

    // pop is registered, so skip the cycle in which the previous pop lands
    always_comb begin
        case (state)
            matrix_pkg::OPCODE:     take = fifo_valid && !pop;
            matrix_pkg::WRITE_BUSY: take = fifo_valid && !pop && !wr_done;
            matrix_pkg::READ_BUSY:  take = fifo_valid && !pop && !rd_busy;
            default:                take = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= matrix_pkg::OPCODE;
            pop       <= 1'b0;
            wr_enable <= 1'b0;
            rd_enable <= 1'b0;
        end else begin
            pop       <= take;
            wr_enable <= take && (state == matrix_pkg::WRITE_BUSY);
            rd_enable <= take && (state == matrix_pkg::READ_BUSY);

            case (state)
                matrix_pkg::OPCODE: begin
                    if (take) begin
                        case (matrix_pkg::opcode_t'(fifo_data))
                            matrix_pkg::OPC_WRITE_PIXEL: state <= matrix_pkg::WRITE_BUSY;
                            matrix_pkg::OPC_READ_PIXEL:  state <= matrix_pkg::READ_BUSY;
                            default:                     state <= matrix_pkg::OPCODE; // dropped
                        endcase
                    end
                end
                matrix_pkg::WRITE_BUSY: begin
                    if (wr_done)
                        state <= matrix_pkg::OPCODE;
                end
                matrix_pkg::READ_BUSY: begin
                    if (rd_done)
                        state <= matrix_pkg::OPCODE;
                end
                default: state <= matrix_pkg::OPCODE;
            endcase
        end
    end

    // byte handed to the handler alongside its enable
    always_ff @(posedge clk) begin
        if (take)
            cmd_data <= fifo_data;
    end

endmodule

/* control/control_cmd_write_pixel.sv */
//##########################################################
// write pixel command handler
//##########################################################
`include "matrix_params.svh"

module control_cmd_write_pixel (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  matrix_pkg::byte_t   data_in,
    output logic                wr_en,
    output matrix_pkg::row_t    wr_row,
    output matrix_pkg::col_t    wr_col,
    output matrix_pkg::chan_t   wr_chan,
    output matrix_pkg::byte_t   wr_data,
    output logic                done
);
    localparam int COL_BYTES    = `MATRIX_COL_BYTES;
    localparam int COL_IDX_BITS = (COL_BYTES > 1) ? $clog2(COL_BYTES) : 1;

    typedef enum logic [1:0] {
        ROW_CAPTURE,
        COLUMN_CAPTURE,
        PIXEL_BYTES
    } write_state_t;

    write_state_t              state;
    logic [COL_IDX_BITS-1:0]   col_idx;   // next column byte, LSB first
    logic [COL_BYTES*8-1:0]    col_bits;
    matrix_pkg::chan_t         chan_cnt;  // channel of the next data byte

    assign wr_col = col_bits[`MATRIX_COL_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ROW_CAPTURE;
            col_idx  <= '0;
            chan_cnt <= '0;
            wr_en    <= 1'b0;
            done     <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            done  <= 1'b0;

            case (state)
                ROW_CAPTURE: begin
                    if (enable) begin
                        col_idx <= '0;
                        state   <= COLUMN_CAPTURE;
                    end
                end
                COLUMN_CAPTURE: begin
                    if (enable) begin
                        if (col_idx == COL_IDX_BITS'(COL_BYTES - 1)) begin
                            // highest channel arrives first
                            chan_cnt <= matrix_pkg::chan_t'(`MATRIX_BYTES_PER_PIXEL - 1);
                            state    <= PIXEL_BYTES;
                        end else begin
                            col_idx <= col_idx + 1'b1;
                        end
                    end
                end
                PIXEL_BYTES: begin
                    if (enable) begin
                        wr_en <= 1'b1;
                        if (chan_cnt == '0) begin
                            done  <= 1'b1; // lands with the last write
                            state <= ROW_CAPTURE;
                        end else begin
                            chan_cnt <= chan_cnt - 1'b1;
                        end
                    end
                end
                default: state <= ROW_CAPTURE;
            endcase
        end
    end

    // address and data registers
    always_ff @(posedge clk) begin
        if (enable) begin
            case (state)
                ROW_CAPTURE:    wr_row <= matrix_pkg::row_t'(data_in);
                COLUMN_CAPTURE: col_bits[col_idx*8 +: 8] <= data_in;
                PIXEL_BYTES: begin
                    wr_chan <= chan_cnt;
                    wr_data <= data_in;
                end
                default: ;
            endcase
        end
    end

endmodule

/* control/control_cmd_read_pixel.sv */
//##########################################################
// read pixel command handler
//##########################################################
`include "matrix_params.svh"

module control_cmd_read_pixel (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  matrix_pkg::byte_t   data_in,
    output logic                rd_en,
    output matrix_pkg::row_t    rd_row,
    output matrix_pkg::col_t    rd_col,
    input  matrix_pkg::pixel_t  rd_pixel,
    output logic                resp_valid,
    output matrix_pkg::byte_t   resp_data,
    output logic                busy,
    output logic                done
);
    localparam int BPP          = `MATRIX_BYTES_PER_PIXEL;
    localparam int COL_BYTES    = `MATRIX_COL_BYTES;
    localparam int COL_IDX_BITS = (COL_BYTES > 1) ? $clog2(COL_BYTES) : 1;

    typedef enum logic [2:0] {
        ROW_CAPTURE,
        COLUMN_CAPTURE,
        READ_ISSUED,    // rd_en is out this cycle
        PIXEL_LATCH,    // rd_pixel valid, first byte goes out
        PIXEL_OUT
    } read_state_t;

    read_state_t             state;
    logic [COL_IDX_BITS-1:0] col_idx;
    logic [COL_BYTES*8-1:0]  col_bits;
    matrix_pkg::pixel_t      pixel_sr;   // remaining bytes, next one on top
    matrix_pkg::chan_t       remaining;

    assign rd_col = col_bits[`MATRIX_COL_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ROW_CAPTURE;
            col_idx    <= '0;
            remaining  <= '0;
            rd_en      <= 1'b0;
            resp_valid <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            rd_en      <= 1'b0;
            resp_valid <= 1'b0;
            done       <= 1'b0;
            if (done)
                busy <= 1'b0; // held through the final byte

            case (state)
                ROW_CAPTURE: begin
                    if (enable) begin
                        col_idx <= '0;
                        state   <= COLUMN_CAPTURE;
                    end
                end
                COLUMN_CAPTURE: begin
                    if (enable) begin
                        if (col_idx == COL_IDX_BITS'(COL_BYTES - 1)) begin
                            rd_en <= 1'b1;
                            busy  <= 1'b1;
                            state <= READ_ISSUED;
                        end else begin
                            col_idx <= col_idx + 1'b1;
                        end
                    end
                end
                READ_ISSUED: state <= PIXEL_LATCH;
                PIXEL_LATCH: begin
                    resp_valid <= 1'b1;
                    remaining  <= matrix_pkg::chan_t'(BPP - 1);
                    if (BPP == 1) begin
                        done  <= 1'b1;
                        state <= ROW_CAPTURE;
                    end else begin
                        state <= PIXEL_OUT;
                    end
                end
                PIXEL_OUT: begin
                    resp_valid <= 1'b1;
                    remaining  <= remaining - 1'b1;
                    if (remaining == matrix_pkg::chan_t'(1)) begin
                        done  <= 1'b1;
                        state <= ROW_CAPTURE;
                    end
                end
                default: state <= ROW_CAPTURE;
            endcase
        end
    end

    // address capture and response shifter
    always_ff @(posedge clk) begin
        if (enable && state == ROW_CAPTURE)
            rd_row <= matrix_pkg::row_t'(data_in);
        if (enable && state == COLUMN_CAPTURE)
            col_bits[col_idx*8 +: 8] <= data_in;
        if (state == PIXEL_LATCH) begin
            resp_data <= rd_pixel[BPP*8-1 -: 8];
            pixel_sr  <= rd_pixel << 8;
        end else if (state == PIXEL_OUT) begin
            resp_data <= pixel_sr[BPP*8-1 -: 8];
            pixel_sr  <= pixel_sr << 8;
        end
    end

endmodule

/* hw/framebuffer.sv */
//##########################################################
// pixel framebuffer
//##########################################################
`include "matrix_params.svh"

module framebuffer (
    input  logic                clk,
    input  logic                wr_en,
    input  matrix_pkg::row_t    wr_row,
    input  matrix_pkg::col_t    wr_col,
    input  matrix_pkg::chan_t   wr_chan,
    input  matrix_pkg::byte_t   wr_data,
    input  logic                rd_en,
    input  matrix_pkg::row_t    rd_row,
    input  matrix_pkg::col_t    rd_col,
    output matrix_pkg::pixel_t  rd_pixel
);
    localparam int ADDR_BITS = `MATRIX_ROW_BITS + `MATRIX_COL_BITS;
    localparam int WORDS     = 1 << ADDR_BITS;

    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] rd_addr;

    // row selects the upper address bits
    assign wr_addr = {wr_row, wr_col};
    assign rd_addr = {rd_row, rd_col};

    // one byte-wide memory per colour channel
    for (genvar g = 0; g < `MATRIX_BYTES_PER_PIXEL; g++) begin : g_lane
        matrix_pkg::byte_t mem [WORDS];
        matrix_pkg::byte_t rd_q;

        always_ff @(posedge clk) begin
            if (wr_en && wr_chan == matrix_pkg::chan_t'(g))
                mem[wr_addr] <= wr_data;
            if (rd_en)
                rd_q <= mem[rd_addr]; // old data on a same-address write
        end

        assign rd_pixel[g*8 +: 8] = rd_q;
    end

endmodule

/* hw/matrix_ctrl_top.sv */
//##########################################################
// LED matrix command controller
//##########################################################
module matrix_ctrl_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                rx_valid,
    input  matrix_pkg::byte_t   rx_data,
    output logic                credit_return,
    output logic                resp_valid,
    output matrix_pkg::byte_t   resp_data
);
    // FIFO to dispatcher
    logic               fifo_valid;
    matrix_pkg::byte_t  fifo_data;
    logic               pop;

    // dispatcher to handlers
    logic               wr_enable;
    logic               rd_enable;
    matrix_pkg::byte_t  cmd_data;
    logic               wr_done;
    logic               rd_done;
    logic               rd_busy;

    // framebuffer ports
    logic               wr_en;
    matrix_pkg::row_t   wr_row;
    matrix_pkg::col_t   wr_col;
    matrix_pkg::chan_t  wr_chan;
    matrix_pkg::byte_t  wr_data;
    logic               rd_en;
    matrix_pkg::row_t   rd_row;
    matrix_pkg::col_t   rd_col;
    matrix_pkg::pixel_t rd_pixel;

    cmd_rx_buffer i_cmd_rx_buffer (
        .clk           (clk),
        .reset         (reset),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .pop           (pop),
        .fifo_valid    (fifo_valid),
        .fifo_data     (fifo_data),
        .credit_return (credit_return)
    );

    control_dispatch i_control_dispatch (
        .clk        (clk),
        .reset      (reset),
        .fifo_valid (fifo_valid),
        .fifo_data  (fifo_data),
        .pop        (pop),
        .wr_enable  (wr_enable),
        .rd_enable  (rd_enable),
        .cmd_data   (cmd_data),
        .wr_done    (wr_done),
        .rd_done    (rd_done),
        .rd_busy    (rd_busy)
    );

    control_cmd_write_pixel i_control_cmd_write_pixel (
        .clk     (clk),
        .reset   (reset),
        .enable  (wr_enable),
        .data_in (cmd_data),
        .wr_en   (wr_en),
        .wr_row  (wr_row),
        .wr_col  (wr_col),
        .wr_chan (wr_chan),
        .wr_data (wr_data),
        .done    (wr_done)
    );

    control_cmd_read_pixel i_control_cmd_read_pixel (
        .clk        (clk),
        .reset      (reset),
        .enable     (rd_enable),
        .data_in    (cmd_data),
        .rd_en      (rd_en),
        .rd_row     (rd_row),
        .rd_col     (rd_col),
        .rd_pixel   (rd_pixel),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .busy       (rd_busy),
        .done       (rd_done)
    );

    framebuffer i_framebuffer (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_row   (wr_row),
        .wr_col   (wr_col),
        .wr_chan  (wr_chan),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_pixel (rd_pixel)
    );

endmodule

/* tb/tb_matrix_ctrl.sv */
//##########################################################
// matrix controller testbench
//##########################################################
`include "matrix_params.svh"

module tb_matrix_ctrl;
    localparam int BPP     = `MATRIX_BYTES_PER_PIXEL;
    localparam int DEPTH   = `MATRIX_RX_DEPTH;
    localparam int TIMEOUT = 2000;  // cycles allowed per wait
    localparam matrix_pkg::byte_t OPC_WRITE = 8'h01;
    localparam matrix_pkg::byte_t OPC_READ  = 8'h02;

    logic               clk;
    logic               reset;
    logic               rx_valid;
    matrix_pkg::byte_t  rx_data;
    logic               credit_return;
    logic               resp_valid;
    matrix_pkg::byte_t  resp_data;

    int                 credits;      // host side credit counter
    int                 min_credits;
    int                 seed;
    matrix_pkg::pixel_t model [int];  // written pixels keyed by {row, col}
    matrix_pkg::byte_t  exp_q [$];    // response bytes still expected
    matrix_pkg::byte_t  want;

    matrix_ctrl_top i_matrix_ctrl_top (
        .clk           (clk),
        .reset         (reset),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .credit_return (credit_return),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data)
    );

    always #2 clk = ~clk;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    // expected pixel for an address, from the write history
    function automatic matrix_pkg::pixel_t expected_pixel(input matrix_pkg::row_t row,
                                                          input matrix_pkg::col_t col);
        return model[int'({row, col})];
    endfunction

    // each credit_return pulse hands one credit back
    always @(posedge clk) begin
        if (!reset && credit_return === 1'b1) begin
            credits = credits + 1;
            assert (credits <= DEPTH)
                else stop_with_error($sformatf("credit counter rose above %0d", DEPTH));
        end
    end

    // response checker
    always @(negedge clk) begin
        if (!reset && resp_valid === 1'b1) begin
            assert (exp_q.size() > 0)
                else stop_with_error($sformatf("stray response byte 0x%02h", resp_data));
            want = exp_q.pop_front();
            assert (resp_data === want)
                else stop_with_error($sformatf("MISMATCH resp_data: got 0x%02h, expected 0x%02h",
                                               resp_data, want));
        end
    end

    // called at a falling edge, leaves at a falling edge
    task automatic send_byte(input matrix_pkg::byte_t b);
        int waited;
        waited = 0;
        while (credits == 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                stop_with_error("host waited too long for a credit");
        end
        rx_valid = 1'b1;
        rx_data  = b;
        credits  = credits - 1;
        if (credits < min_credits)
            min_credits = credits;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic send_addr(input matrix_pkg::row_t row, input matrix_pkg::col_t col);
        int c;
        int i;
        c = int'(col);
        send_byte(matrix_pkg::byte_t'(row));
        for (i = 0; i < `MATRIX_COL_BYTES; i++)
            send_byte(matrix_pkg::byte_t'(c >> (8 * i)));  // low byte first
    endtask

    task automatic write_pixel(input matrix_pkg::row_t row, input matrix_pkg::col_t col,
                               input matrix_pkg::pixel_t px);
        int ch;
        send_byte(OPC_WRITE);
        send_addr(row, col);
        for (ch = BPP - 1; ch >= 0; ch--)
            send_byte(px[ch*8 +: 8]);  // highest channel first
        model[int'({row, col})] = px;
    endtask

    task automatic read_pixel(input matrix_pkg::row_t row, input matrix_pkg::col_t col);
        matrix_pkg::pixel_t px;
        int ch;
        px = expected_pixel(row, col);
        for (ch = BPP - 1; ch >= 0; ch--)
            exp_q.push_back(px[ch*8 +: 8]);
        send_byte(OPC_READ);
        send_addr(row, col);
    endtask

    // wait until every response arrived and all credits are home
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT)
                stop_with_error("expected response bytes never arrived");
        end
        waited = 0;
        while (credits != DEPTH) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT)
                stop_with_error("host credits did not return to full after traffic drained");
        end
        @(negedge clk);
    endtask

    initial begin
        matrix_pkg::row_t   rows [12];
        matrix_pkg::col_t   cols [12];
        matrix_pkg::pixel_t px;
        int                 i;
        clk         = 1'b0;
        reset       = 1'b1;
        rx_valid    = 1'b0;
        rx_data     = '0;
        credits     = DEPTH;
        min_credits = DEPTH;
        seed        = 32'hcd5;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // no traffic, so both outputs stay quiet
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (resp_valid === 1'b0)
                else stop_with_error($sformatf("MISMATCH resp_valid: got 0x%0h, expected 0x0",
                                               resp_valid));
            assert (credit_return === 1'b0)
                else stop_with_error($sformatf("MISMATCH credit_return: got 0x%0h, expected 0x0",
                                               credit_return));
        end

        write_pixel(5'd3, 9'd5, 24'ha1b2c3);
        read_pixel(5'd3, 9'd5);
        wait_idle();

        // random pixels with every other column above 255
        for (i = 0; i < 12; i++) begin
            rows[i] = matrix_pkg::row_t'($random(seed));
            cols[i] = matrix_pkg::col_t'($random(seed));
            if (i % 2 == 0)
                cols[i][8] = 1'b1;
            px = matrix_pkg::pixel_t'($random(seed));
            write_pixel(rows[i], cols[i], px);
        end
        for (i = 0; i < 12; i++)
            read_pixel(rows[i], cols[i]);
        wait_idle();

        // overwrite with neighbours around it
        write_pixel(5'd10, 9'd299, 24'h111111);
        write_pixel(5'd10, 9'd301, 24'h222222);
        write_pixel(5'd9,  9'd300, 24'h333333);
        write_pixel(5'd11, 9'd300, 24'h444444);
        write_pixel(5'd10, 9'd300, 24'h5a5a5a);
        write_pixel(5'd10, 9'd300, 24'hc3d4e5);
        read_pixel(5'd10, 9'd300);
        read_pixel(5'd10, 9'd299);
        read_pixel(5'd10, 9'd301);
        read_pixel(5'd9,  9'd300);
        read_pixel(5'd11, 9'd300);
        wait_idle();

        // junk opcodes between commands
        send_byte(8'h55);
        send_byte(8'h00);
        write_pixel(5'd31, 9'd511, 24'h0f1e2d);
        send_byte(8'hff);
        send_byte(8'h03);
        read_pixel(5'd31, 9'd511);
        send_byte(8'haa);
        wait_idle();

        // back-to-back bursts starting from full credit
        min_credits = DEPTH;
        for (i = 0; i < 4; i++)
            write_pixel(matrix_pkg::row_t'(i), matrix_pkg::col_t'(256 + i),
                        matrix_pkg::pixel_t'($random(seed)));
        for (i = 0; i < 4; i++)
            read_pixel(matrix_pkg::row_t'(i), matrix_pkg::col_t'(256 + i));
        wait_idle();
        // the burst outruns the FIFO, so the host must have run dry exactly at zero
        assert (min_credits == 0)
            else stop_with_error($sformatf("host credits bottomed out at %0d instead of zero",
                                           min_credits));

        repeat (20) @(negedge clk);  // any stray byte shows up here
        if (exp_q.size() == 0 && credits == DEPTH) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_error("test ended with pending responses or missing credits");
        end
    end

endmodule

/* all.f */
+incdir+common
common/matrix_pkg.sv
hw/cmd_rx_buffer.sv
control/control_dispatch.sv
control/control_cmd_write_pixel.sv
control/control_cmd_read_pixel.sv
hw/framebuffer.sv
hw/matrix_ctrl_top.sv
tb/tb_matrix_ctrl.sv
